// File: Makefile
TOP := fetch_tb

.PHONY: all lint clean

# Build and run, then search the output for the pass line
all:
	verilator --binary --assert --top-module $(TOP) -f sim.f -o $(TOP)
	@out="$$(./obj_dir/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "ALL TESTS PASSED"

lint:
	verilator --lint-only -Wall --top-module $(TOP) -f sim.f

clean:
	rm -rf obj_dir

// File: dv/fetch_tb.sv
//////////////////////////////////////////////////////////////////////
// Fetch stage testbench
// Random decode stimulus, reference PC model, checks and report
//////////////////////////////////////////////////////////////////////

`default_nettype none

`include "fetch_cfg.svh"

module fetch_tb import fetch_pkg::*; ();

    localparam int NUM_TRANSFERS = 400;
    // Twelve cycles per transfer is far above the average
    localparam int MAX_CYCLES = NUM_TRANSFERS * 12;
    localparam logic [`FETCH_XLEN-1:0] INSTR_KEY = 32'hA5A5_0000;

    logic         clk;
    logic         rst_n;
    cache_req_t   req;
    logic         req_ready;
    cache_resp_t  resp;
    logic         interrupt_pending;
    f2d_t         f2d;
    d2f_t         d2f;
    int           flush_count;

    // Reference model state is updated at the rising edge only
    logic [`FETCH_XLEN-1:0]  exp_pc = `FETCH_RESET_VECTOR;
    int    exp_flushes = 0;
    logic  flush_check = 1'b0;
    logic  redirect_pending = 1'b0;
    logic  stalled = 1'b0;
    f2d_t  stalled_item = '0;
    logic  released = 1'b0;
    logic  started = 1'b0;
    int    transfers = 0;
    int    irq_items = 0;
    int    value_errors = 0;
    int    protocol_errors = 0;
    int    cycles = 0;

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    fetch_unit i_fetch_unit (
        .clk               (clk),
        .rst_n             (rst_n),
        .req               (req),
        .req_ready         (req_ready),
        .resp              (resp),
        .interrupt_pending (interrupt_pending),
        .f2d               (f2d),
        .d2f               (d2f)
    );

    icache_model i_icache (
        .clk         (clk),
        .rst_n       (rst_n),
        .req         (req),
        .req_ready   (req_ready),
        .resp        (resp),
        .flush_count (flush_count)
    );

    //////////////////////////////////////////////////////////////////////
    // Monitor and reference model
    //////////////////////////////////////////////////////////////////////

    // Compare one transferred instruction with the expected PC
    // The first one after reset is expected at the reset vector
    task automatic check_item();
        assert (f2d.pc == exp_pc) else begin
            value_errors++;
            $display("[FAIL] %0t: pc %h, expected %h", $time, f2d.pc, exp_pc);
        end
        assert (f2d.instr == (exp_pc ^ INSTR_KEY)) else begin
            value_errors++;
            $display("[FAIL] %0t: instr %h for pc %h", $time, f2d.instr, exp_pc);
        end
        assert (f2d.status == exp_pc[`FETCH_STATUS_W-1:0]) else begin
            value_errors++;
            $display("[FAIL] %0t: status %h for pc %h", $time, f2d.status, exp_pc);
        end
        // The first item after a flush follows exactly one FLUSH_ALL
        if (flush_check) begin
            assert (flush_count == exp_flushes) else begin
                value_errors++;
                $display("[FAIL] %0t: flush count %0d, expected %0d",
                         $time, flush_count, exp_flushes);
            end
            flush_check = 1'b0;
        end
        redirect_pending = 1'b0;
        exp_pc = exp_pc + 32'd4;
        transfers++;
    endtask

    always @(posedge clk) begin
        if (rst_n) begin
            if (!released) begin
                // The edge that first sees rst_n high still shows the reset state
                assert (req.cmd == CACHE_CMD_NONE && !f2d.valid) else begin
                    protocol_errors++;
                    $display("[FAIL] %0t: request %h or item valid %b while still in reset",
                             $time, req.cmd, f2d.valid);
                end
                released = 1'b1;
            end else if (!started) begin
                // The pending reset branch goes out in the first cycle after reset
                assert (req.cmd == CACHE_CMD_EXECUTE && req.address == `FETCH_RESET_VECTOR)
                else begin
                    protocol_errors++;
                    $display("[FAIL] %0t: first request %h at %h", $time, req.cmd, req.address);
                end
                started = 1'b1;
            end
            // A stalled instruction is shown again with the same fields
            if (stalled) begin
                assert (f2d == stalled_item) else begin
                    protocol_errors++;
                    $display("[FAIL] %0t: held item changed, pc %h to %h valid %b",
                             $time, stalled_item.pc, f2d.pc, f2d.valid);
                end
            end
            assert (!(interrupt_pending && req_ready && req.cmd == CACHE_CMD_EXECUTE)) else begin
                protocol_errors++;
                $display("[FAIL] %0t: fetch at %h accepted under interrupt", $time, req.address);
            end
            if (f2d.valid && f2d.item_type == F2D_TYPE_INTERRUPT_PENDING) begin
                irq_items++;
            end
            if (f2d.valid && d2f.ready && f2d.item_type == F2D_TYPE_INSTR) begin
                check_item();
            end
            stalled      = f2d.valid && !d2f.ready && f2d.item_type == F2D_TYPE_INSTR;
            stalled_item = f2d;
            // A redirect applies after the item that transferred with it
            if (d2f.ready && d2f.cmd != D2F_CMD_NONE) begin
                exp_pc           = d2f.branch_target;
                redirect_pending = 1'b1;
                if (d2f.cmd == D2F_CMD_FLUSH) begin
                    exp_flushes = flush_count + 1;
                    flush_check = 1'b1;
                end
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: the test did not finish within %0d cycles", MAX_CYCLES);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////////////////////////

    // One decode cycle with random ready
    task automatic drive_decode(input logic allow_redirect);
        int pick;
        @(negedge clk);
        pick              = int'($urandom() % 8);
        d2f.ready         = ($urandom() % 4) != 0;
        d2f.cmd           = D2F_CMD_NONE;
        d2f.branch_target = $urandom() & 32'hFFFF_FFFC;
        // After a stall the item is still shown, so ready high makes a transfer
        if (allow_redirect && stalled && !redirect_pending && pick < 2) begin
            d2f.ready = 1'b1;
            d2f.cmd   = (pick == 0) ? D2F_CMD_FLUSH : D2F_CMD_START_BRANCH;
        end
    endtask

    // Raise the interrupt, wait for its item, then resume with a branch
    task automatic run_interrupt();
        int seen_before;
        drive_decode(1'b0);
        while (redirect_pending) begin
            drive_decode(1'b0);
        end
        interrupt_pending = 1'b1;
        seen_before = irq_items;
        while (irq_items == seen_before) begin
            drive_decode(1'b0);
        end
        repeat (4) drive_decode(1'b0);
        @(negedge clk);
        interrupt_pending = 1'b0;
        d2f.ready         = 1'b1;
        d2f.cmd           = D2F_CMD_START_BRANCH;
        d2f.branch_target = $urandom() & 32'hFFFF_FFFC;
    endtask

    initial begin
        void'($urandom(15));
        rst_n = 1'b0;
        interrupt_pending = 1'b0;
        d2f = '0;
        repeat (10) @(negedge clk);
        rst_n = 1'b1;
        while (transfers < NUM_TRANSFERS) begin
            repeat (60) drive_decode(1'b1);
            run_interrupt();
        end
        // The last resume branch must still reach decode
        drive_decode(1'b0);
        while (redirect_pending) begin
            drive_decode(1'b0);
        end
        $display("Done after %0d transfers: %0d value errors, %0d protocol errors",
                 transfers, value_errors, protocol_errors);
        if (value_errors == 0 && protocol_errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: dv/icache_model.sv
//////////////////////////////////////////////////////////////////////
// Behavioral instruction cache for the fetch testbench
// Random ready, random response latency, FLUSH_ALL counter
//////////////////////////////////////////////////////////////////////

`default_nettype none

`include "fetch_cfg.svh"

module icache_model import fetch_pkg::*; (
    input  logic         clk,
    input  logic         rst_n,
    input  cache_req_t   req,
    output logic         req_ready,
    output cache_resp_t  resp,
    output int           flush_count
);

    // Output registers, defined from time zero
    logic                    ready_q = 1'b0;
    cache_resp_t             resp_q = '0;
    // The request being served and the extra wait cycles left
    logic                    busy;
    int                      wait_left;
    logic [`FETCH_XLEN-1:0]  addr;

    assign req_ready = ready_q;
    assign resp      = resp_q;

    // Requests are taken at the rising edge
    always @(posedge clk) begin
        if (!rst_n) begin
            busy        <= 1'b0;
            wait_left   <= 0;
            flush_count <= 0;
        end else if (req.cmd != CACHE_CMD_NONE && req_ready) begin
            // A new request may arrive in the cycle of the previous response
            busy      <= 1'b1;
            addr      <= req.address;
            wait_left <= int'($urandom() % 5);
            if (req.cmd == CACHE_CMD_FLUSH_ALL) begin
                flush_count <= flush_count + 1;
            end
        end else if (busy) begin
            if (wait_left == 0) begin
                busy <= 1'b0;
            end else begin
                wait_left <= wait_left - 1;
            end
        end
    end

    // Outputs change on the falling edge, the response lasts one cycle
    always @(negedge clk) begin
        ready_q <= ($urandom() % 3) != 0;
        resp_q  <= '0;
        if (busy && wait_left == 0) begin
            resp_q.valid     <= 1'b1;
            resp_q.status    <= addr[`FETCH_STATUS_W-1:0];
            resp_q.read_data <= addr ^ 32'hA5A5_0000;
        end
    end

endmodule

`default_nettype wire

// File: logic/fetch_cfg.svh
//////////////////////////////////////////////////////////////////////
// Fetch stage configuration macros
// Address and instruction width, cache status width, reset vector
//////////////////////////////////////////////////////////////////////

`ifndef FETCH_CFG_SVH
`define FETCH_CFG_SVH

// Width of an address and of one instruction word
`define FETCH_XLEN 32

// Width of the status field returned by the instruction cache
`define FETCH_STATUS_W 4

// Address of the very first fetch after reset
`define FETCH_RESET_VECTOR 32'h0000_1000

`endif

// File: logic/fetch_pkg.sv
//////////////////////////////////////////////////////////////////////
// Fetch stage package
// Cache and decode command encodings, shared packed structs
//////////////////////////////////////////////////////////////////////

`default_nettype none

`include "fetch_cfg.svh"

package fetch_pkg;

    // Commands understood by the instruction cache
    typedef enum logic [3:0] {
        CACHE_CMD_NONE      = 4'd0,
        CACHE_CMD_EXECUTE   = 4'd1,
        CACHE_CMD_FLUSH_ALL = 4'd2
    } cache_cmd_e;

    // Commands that decode sends back to fetch
    typedef enum logic [1:0] {
        D2F_CMD_NONE         = 2'd0,
        D2F_CMD_START_BRANCH = 2'd1,
        D2F_CMD_FLUSH        = 2'd2
    } d2f_cmd_e;

    // Kind of item presented to decode
    typedef enum logic {
        F2D_TYPE_INSTR             = 1'b0,
        F2D_TYPE_INTERRUPT_PENDING = 1'b1
    } f2d_type_e;

    // Request towards the cache, valid whenever cmd is not NONE
    typedef struct packed {
        cache_cmd_e              cmd;
        logic [`FETCH_XLEN-1:0]  address;
    } cache_req_t;

    // One-cycle response from the cache
    typedef struct packed {
        logic                        valid;
        logic [`FETCH_STATUS_W-1:0]  status;
        logic [`FETCH_XLEN-1:0]      read_data;
    } cache_resp_t;

    // Item presented to decode
    typedef struct packed {
        logic                        valid;
        f2d_type_e                   item_type;
        logic [`FETCH_XLEN-1:0]      instr;
        logic [`FETCH_XLEN-1:0]      pc;
        logic [`FETCH_STATUS_W-1:0]  status;
    } f2d_t;

    // Handshake and redirect commands from decode
    typedef struct packed {
        logic                    ready;
        d2f_cmd_e                cmd;
        logic [`FETCH_XLEN-1:0]  branch_target;
    } d2f_t;

    // Effective redirect state handed from the redirect block to the request block
    typedef struct packed {
        logic                    flushing;
        logic                    branching;
        logic [`FETCH_XLEN-1:0]  target;
    } redirect_t;

endpackage

`default_nettype wire

// File: logic/fetch_redirect.sv
//////////////////////////////////////////////////////////////////////
// Fetch redirect tracking
// Pending branch and flush registers, capture of decode commands
//////////////////////////////////////////////////////////////////////

`default_nettype none

`include "fetch_cfg.svh"

module fetch_redirect import fetch_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  d2f_t       d2f,
    input  logic       capture_window,
    input  logic       flush_taken,
    input  logic       branch_taken,
    output redirect_t  redirect,
    output logic       branched
);

    // The -ed registers hold commands seen in an earlier cycle
    // The -ing outputs also include the command on d2f right now
    logic                    flushed;
    logic                    branched_nxt;
    logic                    flushed_nxt;
    logic [`FETCH_XLEN-1:0]  target;
    logic [`FETCH_XLEN-1:0]  target_nxt;
    logic                    d2f_branch;
    logic                    d2f_flush;

    // A decode command only counts in a cycle with ready high
    assign d2f_branch = d2f.ready && (d2f.cmd == D2F_CMD_START_BRANCH);
    assign d2f_flush  = d2f.ready && (d2f.cmd == D2F_CMD_FLUSH);

    // A live command takes effect this cycle without waiting for the registers
    assign redirect.flushing  = flushed || d2f_flush;
    assign redirect.branching = branched || d2f_branch;
    assign redirect.target    = (d2f_branch || d2f_flush) ? d2f.branch_target : target;

    //////////////////////////////////////////////////////////////////////
    // Next state
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        branched_nxt = branched;
        flushed_nxt  = flushed;
        target_nxt   = target;

        // Commands are kept while the stage cannot act on them at once
        if (capture_window && (d2f_branch || d2f_flush)) begin
            branched_nxt = 1'b1;
            target_nxt   = d2f.branch_target;
            flushed_nxt  = d2f_flush;
        end

        // A flush restarts fetching, so once it is sent the branch to its target stays pending
        if (flush_taken) begin
            flushed_nxt  = 1'b0;
            branched_nxt = 1'b1;
        end

        // The branch went out with an accepted request
        if (branch_taken) begin
            branched_nxt = 1'b0;
        end
    end

    // Reset pretends a branch to the reset vector was received
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            branched <= 1'b1;
            flushed  <= 1'b0;
            target   <= `FETCH_RESET_VECTOR;
        end else begin
            branched <= branched_nxt;
            flushed  <= flushed_nxt;
            target   <= target_nxt;
        end
    end

endmodule

`default_nettype wire

// File: logic/fetch_request.sv
//////////////////////////////////////////////////////////////////////
// Fetch request generation
// PC register, accepted command, next cache command and address
//////////////////////////////////////////////////////////////////////

`default_nettype none

`include "fetch_cfg.svh"

module fetch_request import fetch_pkg::*; (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    issue_slot,
    input  logic                    interrupt_pending,
    input  redirect_t               redirect,
    input  logic                    req_ready,
    output cache_req_t              req,
    output logic [`FETCH_XLEN-1:0]  pc,
    output logic                    req_accepted,
    output logic                    req_is_flush,
    output logic                    flush_taken,
    output logic                    branch_taken
);

    // Command of the request most recently accepted by the cache
    cache_cmd_e              last_cmd;
    logic [`FETCH_XLEN-1:0]  pc_plus_4;

    assign pc_plus_4 = pc + `FETCH_XLEN'd4;

    //////////////////////////////////////////////////////////////////////
    // Command selection
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        req.cmd     = CACHE_CMD_NONE;
        req.address = pc;

        // A pending interrupt stops new fetches until decode redirects
        if (issue_slot && !interrupt_pending) begin
            if (redirect.flushing) begin
                // Flush first; the restart branch follows on the next request
                req.cmd = CACHE_CMD_FLUSH_ALL;
            end else if (redirect.branching) begin
                req.cmd     = CACHE_CMD_EXECUTE;
                req.address = redirect.target;
            end else begin
                req.cmd     = CACHE_CMD_EXECUTE;
                req.address = pc_plus_4;
            end
        end
    end

    // The request may change freely until the cache takes it
    assign req_accepted = (req.cmd != CACHE_CMD_NONE) && req_ready;

    // Report which redirect left with the accepted request
    assign flush_taken  = req_accepted && redirect.flushing;
    assign branch_taken = req_accepted && !redirect.flushing && redirect.branching;

    // Tells the buffer that the response in flight belongs to a flush
    assign req_is_flush = (last_cmd == CACHE_CMD_FLUSH_ALL);

    //////////////////////////////////////////////////////////////////////
    // Registers
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            last_cmd <= CACHE_CMD_NONE;
        end else if (req_accepted) begin
            last_cmd <= req.cmd;
        end
    end

    // PC follows the accepted address, a flush keeps it where it was
    always_ff @(posedge clk) begin
        if (req_accepted) begin
            pc <= req.address;
        end
    end

endmodule

`default_nettype wire

// File: logic/fetch_resp_buffer.sv
//////////////////////////////////////////////////////////////////////
// Fetch response buffer
// Outstanding request tracking, stalled response holding register,
// item presented to decode and the issue slot
//////////////////////////////////////////////////////////////////////

`default_nettype none

`include "fetch_cfg.svh"

module fetch_resp_buffer import fetch_pkg::*; (
    input  logic                    clk,
    input  logic                    rst_n,
    input  cache_resp_t             resp,
    input  logic                    req_accepted,
    input  logic                    req_is_flush,
    input  logic [`FETCH_XLEN-1:0]  pc,
    input  logic                    interrupt_pending,
    input  logic                    branched,
    input  logic                    d2f_ready,
    output f2d_t                    f2d,
    output logic                    issue_slot,
    output logic                    capture_window
);

    // Low during reset so that nothing is issued or shown until it is released
    logic                        active;
    // A request sits in the cache pipeline
    logic                        outstanding;
    // Holding register for a response that decode did not take
    logic                        saved_valid;
    logic [`FETCH_XLEN-1:0]      saved_instr;
    logic [`FETCH_STATUS_W-1:0]  saved_status;
    logic                        resp_done;
    logic                        live_item;
    logic                        idle;

    // The cache answers the outstanding request, flushes produce no item
    assign resp_done = resp.valid && outstanding;
    assign live_item = resp_done && !req_is_flush;
    assign idle      = active && !outstanding && !saved_valid;

    //////////////////////////////////////////////////////////////////////
    // Output to decode
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        f2d.valid     = 1'b0;
        f2d.item_type = F2D_TYPE_INSTR;
        f2d.instr     = resp.read_data;
        f2d.pc        = pc;
        f2d.status    = resp.status;

        if (saved_valid) begin
            // Replay the held copy until decode takes it
            f2d.valid  = !branched;
            f2d.instr  = saved_instr;
            f2d.status = saved_status;
        end else if (live_item) begin
            // A branch seen while the fetch was in flight hides its result
            f2d.valid = !branched;
        end else if (idle && interrupt_pending) begin
            // Nothing in flight, so decode can be told about the interrupt
            f2d.valid     = 1'b1;
            f2d.item_type = F2D_TYPE_INTERRUPT_PENDING;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Issue slot and capture window
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        if (saved_valid) begin
            issue_slot = d2f_ready;
        end else if (resp_done) begin
            // Hidden responses free the slot without waiting for decode
            issue_slot = (live_item && !branched) ? d2f_ready : 1'b1;
        end else begin
            issue_slot = idle;
        end
    end

    // Decode commands are registered whenever they cannot be dropped
    assign capture_window = outstanding || issue_slot;

    //////////////////////////////////////////////////////////////////////
    // Control registers
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            active      <= 1'b0;
            outstanding <= 1'b0;
            saved_valid <= 1'b0;
        end else begin
            active <= 1'b1;

            // A new acceptance wins since only one request is in flight
            if (req_accepted) begin
                outstanding <= 1'b1;
            end else if (resp.valid) begin
                outstanding <= 1'b0;
            end

            if (saved_valid && d2f_ready) begin
                saved_valid <= 1'b0;
            end else if (live_item && !branched && !d2f_ready) begin
                saved_valid <= 1'b1;
            end
        end
    end

    // The held response payload
    always_ff @(posedge clk) begin
        if (live_item) begin
            saved_instr  <= resp.read_data;
            saved_status <= resp.status;
        end
    end

endmodule

`default_nettype wire

// File: logic/fetch_unit.sv
//////////////////////////////////////////////////////////////////////
// Instruction fetch stage top level
// Connects redirect, response buffer and request blocks
//////////////////////////////////////////////////////////////////////

`default_nettype none

`include "fetch_cfg.svh"

module fetch_unit import fetch_pkg::*; (
    input  logic         clk,
    input  logic         rst_n,
    output cache_req_t   req,
    input  logic         req_ready,
    input  cache_resp_t  resp,
    input  logic         interrupt_pending,
    output f2d_t         f2d,
    input  d2f_t         d2f
);

    // Handshakes between the three blocks
    redirect_t               redirect;
    logic                    branched;
    logic                    capture_window;
    logic                    issue_slot;
    logic [`FETCH_XLEN-1:0]  pc;
    logic                    req_accepted;
    logic                    req_is_flush;
    logic                    flush_taken;
    logic                    branch_taken;

    // Pending branch and flush state
    fetch_redirect i_redirect (
        .clk            (clk),
        .rst_n          (rst_n),
        .d2f            (d2f),
        .capture_window (capture_window),
        .flush_taken    (flush_taken),
        .branch_taken   (branch_taken),
        .redirect       (redirect),
        .branched       (branched)
    );

    // Response handling and output to decode
    fetch_resp_buffer i_resp_buffer (
        .clk               (clk),
        .rst_n             (rst_n),
        .resp              (resp),
        .req_accepted      (req_accepted),
        .req_is_flush      (req_is_flush),
        .pc                (pc),
        .interrupt_pending (interrupt_pending),
        .branched          (branched),
        .d2f_ready         (d2f.ready),
        .f2d               (f2d),
        .issue_slot        (issue_slot),
        .capture_window    (capture_window)
    );

    // Cache command generation and PC
    fetch_request i_request (
        .clk               (clk),
        .rst_n             (rst_n),
        .issue_slot        (issue_slot),
        .interrupt_pending (interrupt_pending),
        .redirect          (redirect),
        .req_ready         (req_ready),
        .req               (req),
        .pc                (pc),
        .req_accepted      (req_accepted),
        .req_is_flush      (req_is_flush),
        .flush_taken       (flush_taken),
        .branch_taken      (branch_taken)
    );

endmodule

`default_nettype wire

// File: sim.f
+incdir+logic
logic/fetch_pkg.sv
logic/fetch_redirect.sv
logic/fetch_resp_buffer.sv
logic/fetch_request.sv
logic/fetch_unit.sv
dv/icache_model.sv
dv/fetch_tb.sv
